// File: verilog/vdu_pkg.sv
/*
 * vdu shared types: bus request/response, colour and video structs,
 * memory region select and default 640x480 raster values
 */
package vdu_pkg;

    localparam int CORD_W = 16;

    // default raster, 640x480 at 60 Hz
    localparam int DEF_H_ACTIVE = 640;
    localparam int DEF_H_FRONT  = 16;
    localparam int DEF_H_SYNC   = 96;
    localparam int DEF_H_BACK   = 48;
    localparam int DEF_V_ACTIVE = 480;
    localparam int DEF_V_FRONT  = 10;
    localparam int DEF_V_SYNC   = 2;
    localparam int DEF_V_BACK   = 33;

    // 128 KiB frame buffer as 32-bit words
    localparam int DEF_VRAM_WORDS = 32768;

    // addr[15] picks the palette, addr[14:0] is a vram word address
    typedef struct packed {
        logic        sel;
        logic        we;
        logic [3:0]  mask;
        logic [15:0] addr;
        logic [31:0] wdata;
    } bus_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] rdata;
    } bus_rsp_t;

    // palette entry, red in the top nibble
    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb_t;

    typedef struct packed {
        logic hsync;
        logic vsync;
        logic de;
        rgb_t rgb;
    } video_t;

    typedef enum logic {
        REGION_VRAM    = 1'b0,
        REGION_PALETTE = 1'b1
    } region_e;

endpackage

// File: verilog/vdu_bus_decode.sv
/*
 * bus decoder: registers each request, selects vram or palette and
 * returns a single-cycle acknowledge with the addressed read data
 */
module vdu_bus_decode (
    input  logic               clk,
    input  logic               reset_i,
    input  vdu_pkg::bus_req_t  bus_req_i,
    output vdu_pkg::bus_req_t  req_o,
    output vdu_pkg::region_e   region_o,
    input  logic [31:0]        vram_rdata_i,
    input  vdu_pkg::rgb_t      pal_rdata_i,
    output vdu_pkg::bus_rsp_t  bus_rsp_o
);
    import vdu_pkg::*;

    bus_req_t req_q;
    region_e  region_q;

    // select and region
    always_ff @(posedge clk) begin
        if (reset_i) begin
            req_q.sel <= 1'b0;
            region_q  <= REGION_VRAM;
        end else begin
            req_q.sel <= bus_req_i.sel;
            if (bus_req_i.sel) begin
                region_q <= bus_req_i.addr[15] ? REGION_PALETTE : REGION_VRAM;
            end
        end
    end

    // request payload, only captured on a select
    always_ff @(posedge clk) begin
        if (bus_req_i.sel) begin
            req_q.we    <= bus_req_i.we;
            req_q.mask  <= bus_req_i.mask;
            req_q.addr  <= bus_req_i.addr;
            req_q.wdata <= bus_req_i.wdata;
        end
    end

    assign req_o    = req_q;
    assign region_o = region_q;

    // ack one cycle after select
    always_comb begin
        bus_rsp_o.ack = req_q.sel;
        if (region_q == REGION_PALETTE) begin
            bus_rsp_o.rdata = {20'h0, pal_rdata_i};
        end else begin
            bus_rsp_o.rdata = vram_rdata_i;
        end
    end

endmodule

// File: verilog/vdu_vram.sv
/*
 * frame buffer: dual-port word memory, byte-masked bus port and
 * a read-only scan port with one cycle of latency
 */
module vdu_vram #(
    parameter int WORDS = vdu_pkg::DEF_VRAM_WORDS
) (
    input  logic               clk,
    input  vdu_pkg::bus_req_t  req_i,
    input  vdu_pkg::region_e   region_i,
    output logic [31:0]        rdata_o,
    input  logic [14:0]        scan_addr_i,
    output logic [31:0]        scan_data_o
);
    import vdu_pkg::*;

    localparam int AW = $clog2(WORDS);

    logic [31:0]   mem [WORDS];
    logic [AW-1:0] bus_addr;
    logic [AW-1:0] scan_addr;
    logic          bus_wr;

    assign bus_addr  = req_i.addr[AW-1:0];
    assign scan_addr = scan_addr_i[AW-1:0];
    assign bus_wr    = req_i.sel && req_i.we && (region_i == REGION_VRAM);

    // bus port, masked byte writes
    always_ff @(posedge clk) begin
        if (bus_wr) begin
            for (int b = 0; b < 4; b++) begin
                if (req_i.mask[b]) begin
                    mem[bus_addr][8*b +: 8] <= req_i.wdata[8*b +: 8];
                end
            end
        end
    end

    // read data lands in the ack cycle
    assign rdata_o = mem[bus_addr];

    // scan port
    always_ff @(posedge clk) begin
        scan_data_o <= mem[scan_addr];
    end

endmodule

// File: verilog/vdu_display_timings.sv
/*
 * raster timing: horizontal and vertical counters with active-low
 * syncs, data enable and frame/line strobes
 */
module vdu_display_timings #(
    parameter int H_ACTIVE = vdu_pkg::DEF_H_ACTIVE,
    parameter int H_FRONT  = vdu_pkg::DEF_H_FRONT,
    parameter int H_SYNC   = vdu_pkg::DEF_H_SYNC,
    parameter int H_BACK   = vdu_pkg::DEF_H_BACK,
    parameter int V_ACTIVE = vdu_pkg::DEF_V_ACTIVE,
    parameter int V_FRONT  = vdu_pkg::DEF_V_FRONT,
    parameter int V_SYNC   = vdu_pkg::DEF_V_SYNC,
    parameter int V_BACK   = vdu_pkg::DEF_V_BACK
) (
    input  logic                       clk,
    input  logic                       reset_i,
    output logic [vdu_pkg::CORD_W-1:0] sx_o,
    output logic [vdu_pkg::CORD_W-1:0] sy_o,
    output logic                       hsync_o,
    output logic                       vsync_o,
    output logic                       de_o,
    output logic                       frame_o,
    output logic                       line_o
);
    import vdu_pkg::*;

    typedef logic [CORD_W-1:0] cord_t;

    localparam cord_t H_LAST  = cord_t'(H_ACTIVE + H_FRONT + H_SYNC + H_BACK - 1);
    localparam cord_t V_LAST  = cord_t'(V_ACTIVE + V_FRONT + V_SYNC + V_BACK - 1);
    localparam cord_t H_ACT   = cord_t'(H_ACTIVE);
    localparam cord_t V_ACT   = cord_t'(V_ACTIVE);
    localparam cord_t HS_BEG  = cord_t'(H_ACTIVE + H_FRONT);
    localparam cord_t HS_END  = cord_t'(H_ACTIVE + H_FRONT + H_SYNC);
    localparam cord_t VS_BEG  = cord_t'(V_ACTIVE + V_FRONT);
    localparam cord_t VS_END  = cord_t'(V_ACTIVE + V_FRONT + V_SYNC);

    cord_t sx;
    cord_t sy;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            sx <= '0;
            sy <= '0;
        end else if (sx == H_LAST) begin
            sx <= '0;
            if (sy == V_LAST) begin
                sy <= '0;
            end else begin
                sy <= sy + 1'b1;
            end
        end else begin
            sx <= sx + 1'b1;
        end
    end

    assign sx_o = sx;
    assign sy_o = sy;

    // coordinate 0 is the first active pixel, blanking follows
    assign de_o    = (sx < H_ACT) && (sy < V_ACT);
    assign hsync_o = !((sx >= HS_BEG) && (sx < HS_END));
    assign vsync_o = !((sy >= VS_BEG) && (sy < VS_END));
    assign frame_o = (sx == '0) && (sy == '0);
    assign line_o  = (sx == '0);

endmodule

// File: verilog/vdu_pixel_fetch.sv
/*
 * pixel fetcher: walks vram one word per eight pixels and shifts out
 * one palette index per two pixels, each stored row shown twice
 */
module vdu_pixel_fetch #(
    parameter int H_ACTIVE = vdu_pkg::DEF_H_ACTIVE
) (
    input  logic                       clk,
    input  logic                       reset_i,
    input  logic [vdu_pkg::CORD_W-1:0] sx_i,
    input  logic [vdu_pkg::CORD_W-1:0] sy_i,
    input  logic                       hsync_i,
    input  logic                       vsync_i,
    input  logic                       de_i,
    input  logic                       frame_i,
    input  logic                       line_i,
    output logic [14:0]                scan_addr_o,
    input  logic [31:0]                scan_data_i,
    output logic [7:0]                 index_o,
    output logic                       hsync_o,
    output logic                       vsync_o,
    output logic                       de_o
);

    // words per stored row of H_ACTIVE/2 bytes
    localparam logic [14:0] ROW_WORDS = 15'(H_ACTIVE / 8);

    logic [14:0] line_base;
    logic [14:0] fetch_addr;
    logic [31:0] pix_word;

    // line base of the next row to preload
    always_ff @(posedge clk) begin
        if (reset_i) begin
            line_base <= '0;
        end else if (frame_i || !vsync_i) begin
            line_base <= '0;
        end else if (line_i && de_i && sy_i[0]) begin
            line_base <= line_base + ROW_WORDS;
        end
    end

    // fetch address runs ahead of the shifter by one word
    always_ff @(posedge clk) begin
        if (reset_i) begin
            fetch_addr <= '0;
        end else if (!de_i) begin
            fetch_addr <= line_base;
        end else if (sx_i[2:0] == 3'd0) begin
            fetch_addr <= fetch_addr + 1'b1;
        end
    end

    assign scan_addr_o = fetch_addr;

    // preload in blanking, then one byte per pixel pair
    always_ff @(posedge clk) begin
        if (!de_i) begin
            pix_word <= scan_data_i;
        end else if (sx_i[0]) begin
            if (sx_i[2:1] == 2'b11) begin
                pix_word <= scan_data_i;
            end else begin
                pix_word <= pix_word >> 8;
            end
        end
    end

    always_ff @(posedge clk) begin
        index_o <= pix_word[7:0];
    end

    // syncs and de follow the index
    always_ff @(posedge clk) begin
        if (reset_i) begin
            hsync_o <= 1'b1;
            vsync_o <= 1'b1;
            de_o    <= 1'b0;
        end else begin
            hsync_o <= hsync_i;
            vsync_o <= vsync_i;
            de_o    <= de_i;
        end
    end

endmodule

// File: verilog/vdu_palette_out.sv
/*
 * output stage: 256-entry colour table on the bus, lookup of the
 * pixel index and the registered video output
 */
module vdu_palette_out (
    input  logic               clk,
    input  logic               reset_i,
    input  vdu_pkg::bus_req_t  req_i,
    input  vdu_pkg::region_e   region_i,
    output vdu_pkg::rgb_t      rdata_o,
    input  logic [7:0]         index_i,
    input  logic               hsync_i,
    input  logic               vsync_i,
    input  logic               de_i,
    output vdu_pkg::video_t    video_o
);
    import vdu_pkg::*;

    rgb_t palette [256];
    logic pal_wr;

    assign pal_wr = req_i.sel && req_i.we && (region_i == REGION_PALETTE);

    // mask is ignored, data bits 11:0 only
    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < 256; i++) begin
                palette[i] <= '0;
            end
        end else if (pal_wr) begin
            palette[req_i.addr[7:0]] <= req_i.wdata[11:0];
        end
    end

    assign rdata_o = palette[req_i.addr[7:0]];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            video_o.hsync <= 1'b1;
            video_o.vsync <= 1'b1;
            video_o.de    <= 1'b0;
            video_o.rgb   <= '0;
        end else begin
            video_o.hsync <= hsync_i;
            video_o.vsync <= vsync_i;
            video_o.de    <= de_i;
            // black in blanking
            if (de_i) begin
                video_o.rgb <= palette[index_i];
            end else begin
                video_o.rgb <= '0;
            end
        end
    end

endmodule

// File: verilog/vdu.sv
/*
 * video display unit: bus-written frame buffer and palette scanned
 * at half resolution onto sync, de and 4-bit rgb outputs
 */
module vdu #(
    parameter int H_ACTIVE   = vdu_pkg::DEF_H_ACTIVE,
    parameter int H_FRONT    = vdu_pkg::DEF_H_FRONT,
    parameter int H_SYNC     = vdu_pkg::DEF_H_SYNC,
    parameter int H_BACK     = vdu_pkg::DEF_H_BACK,
    parameter int V_ACTIVE   = vdu_pkg::DEF_V_ACTIVE,
    parameter int V_FRONT    = vdu_pkg::DEF_V_FRONT,
    parameter int V_SYNC     = vdu_pkg::DEF_V_SYNC,
    parameter int V_BACK     = vdu_pkg::DEF_V_BACK,
    parameter int VRAM_WORDS = vdu_pkg::DEF_VRAM_WORDS
) (
    input  logic               clk,
    input  logic               reset_i,
    input  vdu_pkg::bus_req_t  bus_req_i,
    output vdu_pkg::bus_rsp_t  bus_rsp_o,
    output vdu_pkg::video_t    video_o
);
    import vdu_pkg::*;

    bus_req_t          req;
    region_e           region;
    logic [31:0]       vram_rdata;
    rgb_t              pal_rdata;
    logic [CORD_W-1:0] sx;
    logic [CORD_W-1:0] sy;
    logic              hsync;
    logic              vsync;
    logic              de;
    logic              frame;
    logic              line;
    logic [14:0]       scan_addr;
    logic [31:0]       scan_data;
    logic [7:0]        index;
    logic              hsync_d;
    logic              vsync_d;
    logic              de_d;

    vdu_bus_decode bus_decode (
        .clk(clk),
        .reset_i(reset_i),
        .bus_req_i(bus_req_i),
        .req_o(req),
        .region_o(region),
        .vram_rdata_i(vram_rdata),
        .pal_rdata_i(pal_rdata),
        .bus_rsp_o(bus_rsp_o)
    );

    vdu_vram #(
        .WORDS(VRAM_WORDS)
    ) vram (
        .clk(clk),
        .req_i(req),
        .region_i(region),
        .rdata_o(vram_rdata),
        .scan_addr_i(scan_addr),
        .scan_data_o(scan_data)
    );

    vdu_display_timings #(
        .H_ACTIVE(H_ACTIVE),
        .H_FRONT(H_FRONT),
        .H_SYNC(H_SYNC),
        .H_BACK(H_BACK),
        .V_ACTIVE(V_ACTIVE),
        .V_FRONT(V_FRONT),
        .V_SYNC(V_SYNC),
        .V_BACK(V_BACK)
    ) display_timings (
        .clk(clk),
        .reset_i(reset_i),
        .sx_o(sx),
        .sy_o(sy),
        .hsync_o(hsync),
        .vsync_o(vsync),
        .de_o(de),
        .frame_o(frame),
        .line_o(line)
    );

    vdu_pixel_fetch #(
        .H_ACTIVE(H_ACTIVE)
    ) pixel_fetch (
        .clk(clk),
        .reset_i(reset_i),
        .sx_i(sx),
        .sy_i(sy),
        .hsync_i(hsync),
        .vsync_i(vsync),
        .de_i(de),
        .frame_i(frame),
        .line_i(line),
        .scan_addr_o(scan_addr),
        .scan_data_i(scan_data),
        .index_o(index),
        .hsync_o(hsync_d),
        .vsync_o(vsync_d),
        .de_o(de_d)
    );

    vdu_palette_out palette_out (
        .clk(clk),
        .reset_i(reset_i),
        .req_i(req),
        .region_i(region),
        .rdata_o(pal_rdata),
        .index_i(index),
        .hsync_i(hsync_d),
        .vsync_i(vsync_d),
        .de_i(de_d),
        .video_o(video_o)
    );

endmodule

// File: sim/vdu_assert.sv
/*
 * bound checker on the vdu bus handshake and video outputs
 */
module vdu_assert (
    input logic              clk,
    input logic              reset_i,
    input vdu_pkg::bus_req_t req_i,
    input vdu_pkg::bus_rsp_t rsp_i,
    input vdu_pkg::video_t   video_i
);

    int fail_count = 0;

    // de only while both syncs are inactive
    de_outside_sync: assert property (@(posedge clk) disable iff (reset_i)
        video_i.de |-> (video_i.hsync && video_i.vsync))
    else begin
        fail_count++;
        $error("de high during a sync pulse");
    end

    black_in_blanking: assert property (@(posedge clk) disable iff (reset_i)
        !video_i.de |-> (video_i.rgb == '0))
    else begin
        fail_count++;
        $error("colour not zero while de is low");
    end

    // ack exactly one cycle after each select
    ack_after_select: assert property (@(posedge clk) disable iff (reset_i)
        rsp_i.ack == $past(req_i.sel))
    else begin
        fail_count++;
        $error("acknowledge does not follow select by one cycle");
    end

endmodule

bind vdu vdu_assert checks (
    .clk(clk),
    .reset_i(reset_i),
    .req_i(bus_req_i),
    .rsp_i(bus_rsp_o),
    .video_i(video_o)
);

// File: sim/vdu_tb.sv
/*
 * vdu testbench: LFSR-driven bus traffic against a vram and palette
 * model, then frame by frame checks of the video output
 */
module vdu_tb;
    import vdu_pkg::*;

    localparam int H_ACTIVE     = 32;
    localparam int H_FRONT      = 2;
    localparam int H_SYNC       = 4;
    localparam int H_BACK       = 2;
    localparam int V_ACTIVE     = 8;
    localparam int V_FRONT      = 1;
    localparam int V_SYNC       = 1;
    localparam int V_BACK       = 1;
    localparam int VRAM_WORDS   = 64;
    localparam int VA_W         = $clog2(VRAM_WORDS);
    localparam int H_TOTAL      = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int FRAME_CYCLES = H_TOTAL * (V_ACTIVE + V_FRONT + V_SYNC + V_BACK);
    localparam int ACK_TIMEOUT  = 4;

    logic        clk;
    logic        reset_i;
    bus_req_t    bus_req;
    bus_rsp_t    bus_rsp;
    video_t      video;
    logic [31:0] lfsr_state;
    logic [31:0] vram_model [VRAM_WORDS];
    logic [11:0] pal_model [256];
    logic [VA_W-1:0] addr_q [$];

    vdu #(
        .H_ACTIVE(H_ACTIVE),
        .H_FRONT(H_FRONT),
        .H_SYNC(H_SYNC),
        .H_BACK(H_BACK),
        .V_ACTIVE(V_ACTIVE),
        .V_FRONT(V_FRONT),
        .V_SYNC(V_SYNC),
        .V_BACK(V_BACK),
        .VRAM_WORDS(VRAM_WORDS)
    ) UUT (
        .clk(clk),
        .reset_i(reset_i),
        .bus_req_i(bus_req),
        .bus_rsp_o(bus_rsp),
        .video_o(video)
    );

    always #2 clk = ~clk;

    task fail_stop(input string line);
        $display("%s", line);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    // one LFSR step per random bit
    function logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_state[0]};
            lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'hD000_0001 : 32'h0);
        end
        return r;
    endfunction

    task check_rsp(input bus_rsp_t got, input bus_rsp_t exp, input bit with_data,
                   input string msg);
        if ((with_data && got !== exp) || (!with_data && got.ack !== exp.ack)) begin
            fail_stop($sformatf("Mismatch at time %0t: %s, got %h expected %h",
                                $time, msg, got, exp));
        end
    endtask

    task check_video(input video_t got, input video_t exp, input bit whole,
                     input string msg);
        if ((whole && got !== exp) || (!whole && got.rgb !== exp.rgb)) begin
            fail_stop($sformatf("Mismatch at time %0t: %s, got %h expected %h",
                                $time, msg, got, exp));
        end
    endtask

    task check_count(input int got, input int exp, input string msg);
        if (got != exp) begin
            fail_stop($sformatf("Mismatch at time %0t: %s, got %0d expected %0d",
                                $time, msg, got, exp));
        end
    endtask

    // one request and the response seen in its ack cycle
    task automatic bus_xfer(input bit we, input logic [15:0] addr, input logic [3:0] mask,
                            input logic [31:0] data, output bus_rsp_t rsp);
        bus_rsp_t idle;
        int       waited;
        idle = '0;
        @(posedge clk);
        bus_req.sel   <= 1'b1;
        bus_req.we    <= we;
        bus_req.mask  <= mask;
        bus_req.addr  <= addr;
        bus_req.wdata <= data;
        @(negedge clk);
        check_rsp(bus_rsp, idle, 1'b0, "acknowledge during the select cycle");
        @(posedge clk);
        bus_req.sel <= 1'b0;
        @(negedge clk);
        waited = 1;
        while (!bus_rsp.ack) begin
            if (waited >= ACK_TIMEOUT) begin
                fail_stop("no acknowledge came within the timeout");
            end else begin
                @(negedge clk);
                waited++;
            end
        end
        check_count(waited, 1, "cycles from select to acknowledge");
        rsp = bus_rsp;
    endtask

    task automatic vram_access(input bit we, input logic [VA_W-1:0] a,
                               input logic [3:0] mask, input logic [31:0] data);
        bus_rsp_t rsp;
        bus_rsp_t exp;
        bus_xfer(we, 16'(a), mask, data, rsp);
        if (we) begin
            for (int b = 0; b < 4; b++) begin
                if (mask[b]) begin
                    vram_model[a][8*b +: 8] = data[8*b +: 8];
                end
            end
        end else begin
            exp.ack   = 1'b1;
            exp.rdata = vram_model[a];
            check_rsp(rsp, exp, 1'b1, $sformatf("vram word %0d", a));
        end
    endtask

    task automatic pal_access(input bit we, input logic [7:0] idx, input logic [3:0] mask,
                              input logic [31:0] data);
        bus_rsp_t rsp;
        bus_rsp_t exp;
        bus_xfer(we, {8'h80, idx}, mask, data, rsp);
        if (we) begin
            pal_model[idx] = data[11:0];
        end else begin
            exp.ack   = 1'b1;
            exp.rdata = {20'h0, pal_model[idx]};
            check_rsp(rsp, exp, 1'b1, $sformatf("palette entry %0d", idx));
        end
    endtask

    // stored pixel is doubled in x and y
    function automatic rgb_t expected_rgb(input int x, input int y);
        int              k;
        logic [VA_W-1:0] wa;
        logic [1:0]      lane;
        logic [31:0]     word;
        logic [7:0]      idx;
        k    = (y / 2) * (H_ACTIVE / 2) + x / 2;
        wa   = VA_W'(k / 4);
        lane = 2'(k % 4);
        word = vram_model[wa];
        idx  = word[8*lane +: 8];
        return rgb_t'(pal_model[idx]);
    endfunction

    task automatic idle_check();
        bus_rsp_t idle;
        video_t   black;
        idle  = '0;
        black = '0;
        for (int i = 0; i < FRAME_CYCLES; i++) begin
            @(negedge clk);
            check_rsp(bus_rsp, idle, 1'b0, "acknowledge before any request");
            check_video(video, black, 1'b0, "colour with a cleared palette");
        end
    endtask

    task automatic wait_vsync_fall();
        int cycles;
        bit prev;
        bit found;
        cycles = 0;
        found  = 1'b0;
        @(negedge clk);
        prev = video.vsync;
        while (!found) begin
            if (cycles >= 2 * FRAME_CYCLES) begin
                fail_stop("vsync did not fall within the timeout");
            end else begin
                @(negedge clk);
                cycles++;
                found = prev && !video.vsync;
                prev  = video.vsync;
            end
        end
    endtask

    // runs from one vsync fall to the next
    task automatic scan_frame(input string tag);
        int     cycles;
        int     n;
        int     hs_len;
        int     hs_count;
        int     vs_len;
        bit     prev_hs;
        bit     prev_vs;
        bit     done;
        video_t v;
        video_t exp;
        cycles   = 0;
        n        = 0;
        vs_len   = 1;
        hs_len   = video.hsync ? 0 : 1;
        hs_count = 0;
        prev_hs  = video.hsync;
        prev_vs  = 1'b0;
        done     = 1'b0;
        while (!done) begin
            if (cycles >= 2 * FRAME_CYCLES) begin
                fail_stop($sformatf("%s did not end within the timeout", tag));
            end else if (n > H_ACTIVE * V_ACTIVE) begin
                fail_stop($sformatf("%s shows more pixels than the active area", tag));
            end else begin
                @(negedge clk);
                cycles++;
                v = video;
                if (v.de) begin
                    exp.hsync = 1'b1;
                    exp.vsync = 1'b1;
                    exp.de    = 1'b1;
                    exp.rgb   = expected_rgb(n % H_ACTIVE, n / H_ACTIVE);
                    check_video(v, exp, 1'b1, $sformatf("%s pixel %0d,%0d", tag,
                                n % H_ACTIVE, n / H_ACTIVE));
                    n++;
                end else begin
                    exp = '0;
                    check_video(v, exp, 1'b0, $sformatf("%s blanking colour", tag));
                end
                if (!v.hsync) begin
                    hs_len++;
                end else if (!prev_hs) begin
                    check_count(hs_len, H_SYNC, "hsync low samples");
                    hs_len = 0;
                    hs_count++;
                end
                if (!v.vsync) begin
                    if (prev_vs) begin
                        done = 1'b1;
                    end else begin
                        vs_len++;
                    end
                end else if (!prev_vs) begin
                    check_count(vs_len, V_SYNC * H_TOTAL, "vsync low samples");
                    vs_len = 0;
                end
                prev_hs = v.hsync;
                prev_vs = v.vsync;
            end
        end
        check_count(n, H_ACTIVE * V_ACTIVE, $sformatf("de samples in %s", tag));
        check_count(hs_count, V_ACTIVE + V_FRONT + V_SYNC + V_BACK,
                    $sformatf("hsync pulses in %s", tag));
    endtask

    initial begin
        logic [31:0]     r;
        logic [VA_W-1:0] a;
        logic [3:0]      m;
        logic [7:0]      idx;
        logic [11:0]     col;
        clk        = 1'b0;
        reset_i    = 1'b1;
        bus_req    = '0;
        lfsr_state = 32'd1;
        for (int i = 0; i < 256; i++) begin
            pal_model[i] = '0;
        end
        repeat (16) @(posedge clk);
        reset_i <= 1'b0;
        idle_check();

        // whole vram first so every model word is known
        for (int i = 0; i < VRAM_WORDS; i++) begin
            r = rand_bits(32);
            vram_access(1'b1, VA_W'(i), 4'hf, r);
        end
        for (int i = 0; i < 24; i++) begin
            r = rand_bits(VA_W);
            a = r[VA_W-1:0];
            r = rand_bits(4);
            m = r[3:0];
            r = rand_bits(32);
            vram_access(1'b1, a, m, r);
            addr_q.push_back(a);
        end
        foreach (addr_q[i]) begin
            vram_access(1'b0, addr_q[i], 4'h0, 32'h0);
        end

        // palette ignores the random mask
        for (int i = 0; i < 256; i++) begin
            r = rand_bits(4);
            m = r[3:0];
            r = rand_bits(32);
            pal_access(1'b1, 8'(i), m, r);
        end
        for (int i = 0; i < 48; i++) begin
            r = rand_bits(8);
            pal_access(1'b0, r[7:0], 4'h0, 32'h0);
        end

        wait_vsync_fall();
        scan_frame("first frame");
        scan_frame("second frame");

        // recolour the index under the top left pixel
        idx = vram_model[0][7:0];
        r   = rand_bits(12);
        col = pal_model[idx] ^ (r[11:0] | 12'h001);
        pal_access(1'b1, idx, 4'h0, {20'h0, col});
        wait_vsync_fall();
        scan_frame("frame after palette update");

        if (UUT.checks.fail_count != 0) begin
            fail_stop("a bound assertion failed during the run");
        end else begin
            $display("TEST OK");
            $finish;
        end
    end

endmodule

// File: tb.f
verilog/vdu_pkg.sv
verilog/vdu_bus_decode.sv
verilog/vdu_vram.sv
verilog/vdu_display_timings.sv
verilog/vdu_pixel_fetch.sv
verilog/vdu_palette_out.sv
verilog/vdu.sv
sim/vdu_assert.sv
sim/vdu_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the vdu testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert -j 0 --top-module vdu_tb -f tb.f -o vdu_tb_sim; then
    echo "Verilator build failed"
    exit 1
fi

if ! output=$(./obj_dir/vdu_tb_sim); then
    printf '%s\n' "$output"
    echo "simulation exited with an error"
    exit 1
fi
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "TEST OK"; then
    exit 0
fi
exit 1
